// File: verilog/ecc_sram_pkg.sv
// ECC scratchpad memory shared definitions
// Widths, bank depth, the Hsiao (39,32) check matrix and the
// request/response structs of the data bus and the SRAM bank port
package ecc_sram_pkg;

  localparam int unsigned DataWidth     = 32;
  localparam int unsigned CodeWidth     = 39;
  localparam int unsigned CheckWidth    = CodeWidth - DataWidth;
  localparam int unsigned BeWidth       = DataWidth / 8;
  localparam int unsigned BankWords     = 256;
  localparam int unsigned BankAddrWidth = 8;

  // H-matrix data columns are the first 32 weight-3 vectors in order
  // Check bit j owns the unit column 1 << j
  localparam logic [DataWidth-1:0][CheckWidth-1:0] SecdedCols = {
    7'd98, 7'd97, 7'd88, 7'd84, 7'd82, 7'd81, 7'd76, 7'd74,
    7'd73, 7'd70, 7'd69, 7'd67, 7'd56, 7'd52, 7'd50, 7'd49,
    7'd44, 7'd42, 7'd41, 7'd38, 7'd37, 7'd35, 7'd28, 7'd26,
    7'd25, 7'd22, 7'd21, 7'd19, 7'd14, 7'd13, 7'd11, 7'd7
  };

  // Bus request from the master
  typedef struct packed {
    logic                 req;
    logic                 we;    // 1 means store
    logic [31:0]          addr;  // Byte address
    logic [DataWidth-1:0] wdata;
    logic [BeWidth-1:0]   be;
  } tcdm_req_t;

  // Bus response to the master
  typedef struct packed {
    logic                 gnt;
    logic [DataWidth-1:0] rdata;
    logic                 single_err; // Corrected on the way out
    logic                 multi_err;
  } tcdm_rsp_t;

  // Codeword access to the bank
  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [BankAddrWidth-1:0] addr;
    logic [CodeWidth-1:0]     wdata;
  } bank_req_t;

endpackage

// File: verilog/secded_39_32_enc.sv
// Hsiao SECDED (39,32) encoder
// Data passes through in the low 32 bits; each of the 7 check bits is
// the parity of the data bits whose matrix column has that bit set
`timescale 1ns/1ps

module secded_39_32_enc (
  input  logic [ecc_sram_pkg::DataWidth-1:0] data_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] code_o
);

  import ecc_sram_pkg::*;

  logic [CheckWidth-1:0] check;

  // Accumulate the column of every set data bit
  always_comb begin : proc_check
    check = '0;
    for (int i = 0; i < DataWidth; i++) begin
      check = check ^ ({CheckWidth{data_i[i]}} & SecdedCols[i]);
    end
  end

  assign code_o = {check, data_i};

endmodule

// File: verilog/secded_39_32_dec.sv
// Hsiao SECDED (39,32) decoder
// Recomputes the check bits over the received data and compares them with
// the stored ones. An odd syndrome is a single error and is corrected when
// it points at a data bit; a nonzero even syndrome is a double error.
`timescale 1ns/1ps

module secded_39_32_dec (
  input  logic [ecc_sram_pkg::CodeWidth-1:0]                         code_i,
  output logic [ecc_sram_pkg::DataWidth-1:0]                         data_o,
  output logic [ecc_sram_pkg::CodeWidth-ecc_sram_pkg::DataWidth-1:0] syndrome_o,
  output logic                                                       single_err_o,
  output logic                                                       multi_err_o
);

  import ecc_sram_pkg::*;

  logic [CheckWidth-1:0] syndrome;
  logic                  odd_weight;

  // Stored check bits xor recomputed ones
  always_comb begin : proc_syndrome
    syndrome = code_i[CodeWidth-1:DataWidth];
    for (int i = 0; i < DataWidth; i++) begin
      syndrome = syndrome ^ ({CheckWidth{code_i[i]}} & SecdedCols[i]);
    end
  end

  // Flip the one data bit whose column matches
  always_comb begin : proc_correct
    for (int i = 0; i < DataWidth; i++) begin
      data_o[i] = code_i[i] ^ (syndrome == SecdedCols[i]);
    end
  end

  assign odd_weight   = ^syndrome;
  assign syndrome_o   = syndrome;
  assign single_err_o = odd_weight;                 // Check-bit hits land here too
  assign multi_err_o  = (|syndrome) & ~odd_weight;

endmodule

// File: verilog/sram_bank.sv
// Single-port codeword SRAM
// One-cycle read latency, per-bit write enable, cleared to zero codewords
// at reset so that every word decodes clean
`timescale 1ns/1ps

module sram_bank (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  ecc_sram_pkg::bank_req_t            bank_req_i,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] bit_we_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] rdata_o
);

  import ecc_sram_pkg::*;

  logic [CodeWidth-1:0] mem_q [BankWords];
  logic [CodeWidth-1:0] rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_mem
    if (!rst_ni) begin
      for (int w = 0; w < BankWords; w++) begin
        mem_q[w] <= '0;
      end
    end else if (bank_req_i.req && bank_req_i.we) begin
      // Only enabled bits change
      mem_q[bank_req_i.addr] <= (mem_q[bank_req_i.addr] & ~bit_we_i) |
                                (bank_req_i.wdata & bit_we_i);
    end
  end

  always_ff @(posedge clk_i) begin : proc_read
    if (bank_req_i.req && !bank_req_i.we) begin
      rdata_q <= mem_q[bank_req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: verilog/ecc_scrubber.sv
// Background ECC scrubber
// Passes the access port through to the bank. On a trigger it reads the
// word at its address counter in an idle cycle, checks it the next cycle,
// writes back corrected single errors and reports double errors.
`timescale 1ns/1ps

module ecc_scrubber (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scrub_trigger_i,
  output logic                               bit_corrected_o,
  output logic                               uncorrectable_o,
  input  ecc_sram_pkg::bank_req_t            intc_req_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] intc_rdata_o,
  output ecc_sram_pkg::bank_req_t            bank_req_o,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] bank_rdata_i
);

  import ecc_sram_pkg::*;

  typedef enum logic [1:0] {IDLE, READ, CHECK} scrub_state_e;

  scrub_state_e             state_d, state_q;
  logic                     pending_d, pending_q;
  logic [BankAddrWidth-1:0] addr_d, addr_q;
  logic                     fix_d, fix_q;
  logic                     uncorr_d, uncorr_q;
  logic                     done;

  logic [DataWidth-1:0]     fixed_data;
  logic [CodeWidth-1:0]     fixed_code;
  logic                     single_err;
  logic                     multi_err;
  bank_req_t                scrub_req;

  // Checks the word read in the previous cycle
  secded_39_32_dec u_dec (
    .code_i       (bank_rdata_i),
    .data_o       (fixed_data),
    .syndrome_o   (),
    .single_err_o (single_err),
    .multi_err_o  (multi_err)
  );

  // Clean codeword for the fix write
  secded_39_32_enc u_enc (
    .data_i (fixed_data),
    .code_o (fixed_code)
  );

  always_comb begin : proc_fsm
    state_d         = state_q;
    addr_d          = addr_q;
    fix_d           = 1'b0;
    uncorr_d        = 1'b0;
    done            = 1'b0;
    scrub_req       = '0;
    scrub_req.addr  = addr_q;
    scrub_req.wdata = fixed_code;

    unique case (state_q)
      IDLE: begin
        if (pending_q || scrub_trigger_i) state_d = READ;
      end
      READ: begin
        // Wait for a cycle the access port leaves free
        if (!intc_req_i.req) begin
          scrub_req.req = 1'b1;
          state_d       = CHECK;
        end
      end
      CHECK: begin
        if (intc_req_i.req) begin
          state_d = READ;    // Drop the result and read again while the port is busy
        end else begin
          done    = 1'b1;
          state_d = IDLE;
          addr_d  = addr_q + 1'b1; // Wraps at the bank end
          if (single_err) begin
            scrub_req.req = 1'b1;
            scrub_req.we  = 1'b1;
            fix_d         = 1'b1;
          end else if (multi_err) begin
            uncorr_d = 1'b1;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // A trigger arriving as a pass completes queues the next one
  assign pending_d = scrub_trigger_i | (pending_q & ~done);

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      state_q   <= IDLE;
      pending_q <= 1'b0;
      addr_q    <= '0;
      fix_q     <= 1'b0;
      uncorr_q  <= 1'b0;
    end else begin
      state_q   <= state_d;
      pending_q <= pending_d;
      addr_q    <= addr_d;
      fix_q     <= fix_d;
      uncorr_q  <= uncorr_d;
    end
  end

  // The access port always has priority
  assign bank_req_o      = intc_req_i.req ? intc_req_i : scrub_req;
  assign intc_rdata_o    = bank_rdata_i;
  assign bit_corrected_o = fix_q;
  assign uncorrectable_o = uncorr_q;

endmodule

// File: verilog/ecc_sram_wrap.sv
// ECC-protected scratchpad bank for a data memory port
// Loads return corrected data with error flags one cycle after the grant.
// Full-word stores are encoded and written directly; partial stores read
// the old word, merge the new bytes over it and write it back in a second
// cycle with the grant held low. A scrubber shares the bank port.
`timescale 1ns/1ps

module ecc_sram_wrap (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scrub_trigger_i,
  output logic                               scrubber_fix_o,
  output logic                               scrub_uncorrectable_o,
  input  ecc_sram_pkg::tcdm_req_t            tcdm_req_i,
  output ecc_sram_pkg::tcdm_rsp_t            tcdm_rsp_o,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] test_write_mask_ni
);

  import ecc_sram_pkg::*;

  typedef enum logic {NORMAL, MERGE} store_state_e;

  store_state_e             state_d, state_q;
  logic                     gnt;
  logic                     accepted;
  logic                     partial_store;
  logic [BankAddrWidth-1:0] req_addr;
  logic                     valid_read_d, valid_read_q;

  // Partial store buffers, held for the merge cycle
  logic [BankAddrWidth-1:0] addr_buf_q;
  logic [DataWidth-1:0]     wdata_buf_q;
  logic [BeWidth-1:0]       be_buf_q;

  logic [DataWidth-1:0]     be_mask;
  logic [DataWidth-1:0]     merged;
  logic [DataWidth-1:0]     to_encode;
  logic [DataWidth-1:0]     loaded;
  logic [CodeWidth-1:0]     enc_code;
  logic [CodeWidth-1:0]     code_rdata;
  logic [CodeWidth-1:0]     sram_rdata;
  logic                     dec_single;
  logic                     dec_multi;

  bank_req_t                intc_req;
  bank_req_t                sram_req;

  assign req_addr      = tcdm_req_i.addr[BankAddrWidth+1:2]; // Byte to word address
  assign gnt           = (state_q == NORMAL);
  assign accepted      = tcdm_req_i.req & gnt;
  assign partial_store = accepted & tcdm_req_i.we & (tcdm_req_i.be != {BeWidth{1'b1}});

  // Loads and the read half of partial stores both produce flags
  assign valid_read_d  = accepted & (~tcdm_req_i.we | partial_store);

  always_comb begin : proc_be_mask
    for (int b = 0; b < BeWidth; b++) begin
      be_mask[8*b +: 8] = {8{be_buf_q[b]}};
    end
  end

  // New bytes over the corrected old word
  assign merged    = (be_mask & wdata_buf_q) | (~be_mask & loaded);
  assign to_encode = (state_q == MERGE) ? merged : tcdm_req_i.wdata;

  always_comb begin : proc_store_fsm
    state_d        = NORMAL;
    intc_req.req   = tcdm_req_i.req;
    intc_req.we    = tcdm_req_i.we;
    intc_req.addr  = req_addr;
    intc_req.wdata = enc_code;
    if (state_q == NORMAL) begin
      if (partial_store) begin
        intc_req.we = 1'b0; // Fetch the old word first
        state_d     = MERGE;
      end
    end else begin
      intc_req.req  = 1'b1;
      intc_req.we   = 1'b1;
      intc_req.addr = addr_buf_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : proc_state
    if (!rst_ni) begin
      state_q      <= NORMAL;
      valid_read_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_read_q <= valid_read_d;
    end
  end

  always_ff @(posedge clk_i) begin : proc_buffers
    if (partial_store) begin
      addr_buf_q  <= req_addr;
      wdata_buf_q <= tcdm_req_i.wdata;
      be_buf_q    <= tcdm_req_i.be;
    end
  end

  secded_39_32_enc u_enc (
    .data_i (to_encode),
    .code_o (enc_code)
  );

  secded_39_32_dec u_dec (
    .code_i       (code_rdata),
    .data_o       (loaded),
    .syndrome_o   (),
    .single_err_o (dec_single),
    .multi_err_o  (dec_multi)
  );

  ecc_scrubber u_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_trigger_i (scrub_trigger_i),
    .bit_corrected_o (scrubber_fix_o),
    .uncorrectable_o (scrub_uncorrectable_o),
    .intc_req_i      (intc_req),
    .intc_rdata_o    (code_rdata),
    .bank_req_o      (sram_req),
    .bank_rdata_i    (sram_rdata)
  );

  // Mask bits are active low, so an all-zero mask writes every bit
  sram_bank u_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bank_req_i (sram_req),
    .bit_we_i   (~test_write_mask_ni),
    .rdata_o    (sram_rdata)
  );

  assign tcdm_rsp_o.gnt        = gnt;
  assign tcdm_rsp_o.rdata      = loaded;
  assign tcdm_rsp_o.single_err = dec_single & valid_read_q;
  assign tcdm_rsp_o.multi_err  = dec_multi & valid_read_q;

endmodule

// File: test/tb_clk_gen.sv
// Testbench clock and reset source
// 10 ns clock, active-low reset held for the first 10 cycles
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int unsigned HalfPeriod  = 5;
  localparam int unsigned ResetCycles = 10;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_no <= 1'b1; // Released on a rising edge
  end

endmodule

// File: test/ecc_sram_tb.sv
// Testbench for the ECC scratchpad bank
// Directed tests of loads, full and partial stores, injected single and
// double bit errors and background scrubbing, checked against a data model
`timescale 1ns/1ps

module ecc_sram_tb;

  import ecc_sram_pkg::*;

  localparam int unsigned TestCount     = 6;
  localparam int unsigned CyclesPerTest = 200;
  localparam int unsigned ScrubWindow   = 10;
  localparam int unsigned LoadCount     = 20;

  logic                 clk;
  logic                 rst_n;
  logic                 scrub_trigger;
  logic                 scrub_fix;
  logic                 scrub_uncorr;
  tcdm_req_t            tcdm_req;
  tcdm_rsp_t            tcdm_rsp;
  logic [CodeWidth-1:0] write_mask;     // Active low per bit

  logic [DataWidth-1:0] ref_mem [BankWords]; // Expected data of every word

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  ecc_sram_wrap u_dut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .scrub_trigger_i       (scrub_trigger),
    .scrubber_fix_o        (scrub_fix),
    .scrub_uncorrectable_o (scrub_uncorr),
    .tcdm_req_i            (tcdm_req),
    .tcdm_rsp_o            (tcdm_rsp),
    .test_write_mask_ni    (write_mask)
  );

  function automatic tcdm_req_t make_req(input logic we, input logic [BankAddrWidth-1:0] addr,
                                         input logic [DataWidth-1:0] data,
                                         input logic [BeWidth-1:0] be);
    tcdm_req_t r;
    r.req   = 1'b1;
    r.we    = we;
    r.addr  = {{(32-BankAddrWidth-2){1'b0}}, addr, 2'b00}; // Word aligned
    r.wdata = data;
    r.be    = be;
    return r;
  endfunction

  // Lanes with their enable set take the new byte
  function automatic logic [DataWidth-1:0] merge_bytes(input logic [DataWidth-1:0] old_word,
                                                       input logic [DataWidth-1:0] new_word,
                                                       input logic [BeWidth-1:0] be);
    logic [DataWidth-1:0] result;
    result = old_word;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  function automatic tcdm_rsp_t expect_flags(input logic single_err, input logic multi_err);
    tcdm_rsp_t rsp;
    rsp            = '0;
    rsp.single_err = single_err;
    rsp.multi_err  = multi_err;
    return rsp;
  endfunction

  // Two distinct data bit positions
  function automatic logic [DataWidth-1:0] two_bits();
    int first;
    int second;
    first  = $urandom_range(DataWidth - 1);
    second = (first + 1 + $urandom_range(DataWidth - 2)) % DataWidth;
    return (DataWidth'(1) << first) | (DataWidth'(1) << second);
  endfunction

  task automatic check_data(input string name, input logic [DataWidth-1:0] exp_data,
                            input logic [DataWidth-1:0] act_data);
    if (act_data !== exp_data) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_data, act_data);
      $display("STATUS: FAIL");
      $fatal(1, "data mismatch");
    end
  endtask

  task automatic check_flags(input string name, input tcdm_rsp_t exp_rsp,
                             input tcdm_rsp_t act_rsp);
    if (act_rsp.single_err !== exp_rsp.single_err ||
        act_rsp.multi_err !== exp_rsp.multi_err) begin
      $display("[ERROR] %s: expected single/multi %b%b, actual %b%b", name,
               exp_rsp.single_err, exp_rsp.multi_err, act_rsp.single_err, act_rsp.multi_err);
      $display("STATUS: FAIL");
      $fatal(1, "error flag mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
    if (act_bit !== exp_bit) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp_bit, act_bit);
      $display("STATUS: FAIL");
      $fatal(1, "event mismatch");
    end
  endtask

  task automatic bus_idle();
    tcdm_req   <= '0;
    write_mask <= '0;
  endtask

  // Drives a request and holds it until granted; returns on the accepting edge
  task automatic send(input tcdm_req_t r, input logic [CodeWidth-1:0] mask, output int stalls);
    tcdm_req   <= r;
    write_mask <= mask;
    stalls = 0;
    @(negedge clk);
    while (!tcdm_rsp.gnt) begin
      stalls++;
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  task automatic store(input logic [BankAddrWidth-1:0] addr, input logic [DataWidth-1:0] data,
                       input logic [BeWidth-1:0] be, output int stalls);
    send(make_req(1'b1, addr, data, be), '0, stalls);
    ref_mem[addr] = merge_bytes(ref_mem[addr], data, be);
  endtask

  task automatic load(input logic [BankAddrWidth-1:0] addr, output tcdm_rsp_t rsp);
    int stalls;
    send(make_req(1'b0, addr, '0, '0), '0, stalls);
    bus_idle();
    @(negedge clk);
    rsp = tcdm_rsp;   // Response cycle after the grant
    @(posedge clk);
  endtask

  task automatic load_check(input string name, input logic [BankAddrWidth-1:0] addr,
                            input logic exp_single, input logic exp_multi);
    tcdm_rsp_t rsp;
    load(addr, rsp);
    check_data(name, ref_mem[addr], rsp.rdata);
    check_flags(name, expect_flags(exp_single, exp_multi), rsp);
  endtask

  // Writes only the flipped bits so the stored check bits stay those of the model
  task automatic inject(input logic [BankAddrWidth-1:0] addr, input logic [DataWidth-1:0] flips);
    int stalls;
    send(make_req(1'b1, addr, ref_mem[addr] ^ flips, '1),
         ~{{(CodeWidth-DataWidth){1'b0}}, flips}, stalls);
  endtask

  // Merge cycle right after a partial store was accepted
  task automatic finish_partial(input string name, input logic exp_single,
                                input logic exp_multi);
    bus_idle();
    @(negedge clk);
    check_bit({name, " gnt in merge"}, 1'b0, tcdm_rsp.gnt);
    check_flags({name, " merge flags"}, expect_flags(exp_single, exp_multi), tcdm_rsp);
    @(posedge clk);
    @(negedge clk);
    check_bit({name, " gnt after merge"}, 1'b1, tcdm_rsp.gnt);
    check_flags({name, " idle flags"}, expect_flags(1'b0, 1'b0), tcdm_rsp);
    @(posedge clk);
  endtask

  task automatic scrub_pass(input string name, input logic exp_fix, input logic exp_uncorr);
    logic saw_fix;
    logic saw_uncorr;
    bus_idle();
    scrub_trigger <= 1'b1;
    @(posedge clk);
    scrub_trigger <= 1'b0;
    saw_fix    = 1'b0;
    saw_uncorr = 1'b0;
    repeat (ScrubWindow) begin
      @(negedge clk);
      saw_fix    = saw_fix | scrub_fix;
      saw_uncorr = saw_uncorr | scrub_uncorr;
    end
    @(posedge clk);
    check_bit({name, " fix pulse"}, exp_fix, saw_fix);
    check_bit({name, " uncorrectable pulse"}, exp_uncorr, saw_uncorr);
  endtask

  task automatic test_full_store_load();
    logic [BankAddrWidth-1:0] addrs [LoadCount];
    int stalls;
    for (int i = 0; i < LoadCount; i++) begin
      addrs[i] = BankAddrWidth'($urandom_range(BankWords - 1));
      store(addrs[i], $urandom(), '1, stalls);
    end
    for (int i = 0; i < LoadCount; i++) begin
      load_check("full_store_load", addrs[i], 1'b0, 1'b0);
    end
  endtask

  task automatic test_partial_store();
    logic [BankAddrWidth-1:0] addr;
    int stalls;
    for (int pattern = 0; pattern < (1 << BeWidth) - 1; pattern++) begin
      addr = BankAddrWidth'(64 + pattern);
      store(addr, $urandom(), '1, stalls);
      store(addr, $urandom(), BeWidth'(pattern), stalls);
      check_bit("partial_store wait", 1'b0, stalls != 0);
      finish_partial("partial_store", 1'b0, 1'b0);
      load_check("partial_store", addr, 1'b0, 1'b0);
    end
  endtask

  task automatic test_back_to_back();
    int stalls;
    store(BankAddrWidth'(80), $urandom(), 4'b0001, stalls);
    store(BankAddrWidth'(81), $urandom(), 4'b1110, stalls); // Lands in the merge cycle
    check_bit("back_to_back wait", 1'b1, stalls == 1);
    finish_partial("back_to_back", 1'b0, 1'b0);
    load_check("back_to_back first", BankAddrWidth'(80), 1'b0, 1'b0);
    load_check("back_to_back second", BankAddrWidth'(81), 1'b0, 1'b0);
  endtask

  task automatic test_single_error();
    logic [BankAddrWidth-1:0] addr;
    int bit_pos;
    int stalls;
    addr = BankAddrWidth'($urandom_range(BankWords - 1));
    store(addr, $urandom(), '1, stalls);
    // Flipped bit sits in lane 0 or 3, which the partial store below keeps
    bit_pos = $urandom_range(15);
    if (bit_pos >= 8) begin
      bit_pos = bit_pos + 16;
    end
    inject(addr, DataWidth'(1) << bit_pos);
    load_check("single_error", addr, 1'b1, 1'b0);
    store(addr, $urandom(), 4'b0110, stalls);
    finish_partial("single_error merge", 1'b1, 1'b0);
    load_check("single_error merge", addr, 1'b0, 1'b0);
  endtask

  task automatic test_double_error();
    logic [BankAddrWidth-1:0] addr;
    tcdm_rsp_t rsp;
    int stalls;
    addr = BankAddrWidth'($urandom_range(BankWords - 1));
    store(addr, $urandom(), '1, stalls);
    inject(addr, two_bits());
    load(addr, rsp);    // Data is not trusted here
    check_flags("double_error", expect_flags(1'b0, 1'b1), rsp);
  endtask

  task automatic test_scrub();
    int stalls;
    store(BankAddrWidth'(0), $urandom(), '1, stalls);
    inject(BankAddrWidth'(0), DataWidth'(1) << $urandom_range(DataWidth - 1));
    store(BankAddrWidth'(1), $urandom(), '1, stalls);
    inject(BankAddrWidth'(1), two_bits());
    store(BankAddrWidth'(2), $urandom(), '1, stalls);
    scrub_pass("scrub fix", 1'b1, 1'b0);
    load_check("scrub fix reload", BankAddrWidth'(0), 1'b0, 1'b0);
    scrub_pass("scrub uncorrectable", 1'b0, 1'b1);
    scrub_pass("scrub clean", 1'b0, 1'b0);
  endtask

  initial begin : watchdog
    repeat (TestCount * CyclesPerTest) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles", TestCount * CyclesPerTest);
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    void'($urandom(32'hf6f6));
    tcdm_req      = '0;
    write_mask    = '0;
    scrub_trigger = 1'b0;
    for (int w = 0; w < BankWords; w++) begin
      ref_mem[w] = '0;   // Bank resets to zero codewords
    end
    @(posedge rst_n);
    @(posedge clk);
    test_full_store_load();
    test_partial_store();
    test_back_to_back();
    test_single_error();
    test_double_error();
    test_scrub();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: ecc_sram.f
verilog/ecc_sram_pkg.sv
verilog/secded_39_32_enc.sv
verilog/secded_39_32_dec.sv
verilog/sram_bank.sv
verilog/ecc_scrubber.sv
verilog/ecc_sram_wrap.sv
test/tb_clk_gen.sv
test/ecc_sram_tb.sv
